//--- Bender.yml
package:
  name: execute_stage

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/exStagePkg.sv
      - src/aluControl.sv
      - src/alu.sv
      - src/forwardUnit.sv
      - src/targetCalc.sv
      - src/executeStage.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/executeStage_asserts.sv
      - testbench/executeStage_tb.sv

//--- list.f
+incdir+src
src/exStagePkg.sv
src/aluControl.sv
src/alu.sv
src/forwardUnit.sv
src/targetCalc.sv
src/executeStage.sv
testbench/executeStage_asserts.sv
testbench/executeStage_tb.sv

//--- src/alu.sv
`timescale 1ns/1ps

`include "exStage_config.svh"

module alu import exStagePkg::*; (
    input  aluOperation            operation,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   zero
);

    logic [4:0] shiftAmount;
    logic       lessSigned;
    logic       lessUnsigned;

    // Shifts use the low five bits of A as the distance
    assign shiftAmount  = a[4:0];
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (operation)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluNor:  result = ~(a | b);
            aluSlt: begin
                result = '0;
                result[0] = lessSigned;
            end
            aluSltu: begin
                result = '0;
                result[0] = lessUnsigned;
            end
            aluSll:  result = b << shiftAmount;
            aluSrl:  result = b >> shiftAmount;
            aluSra:  result = $unsigned($signed(b) >>> shiftAmount);
            aluLui: begin
                result = '0;
                result[`DATA_WIDTH-1:`DATA_WIDTH/2] = b[`DATA_WIDTH/2-1:0];
            end
            default: result = '0;
        endcase
    end

    // Branch equality is taken from a subtraction that comes out zero
    assign zero = (result == '0);

endmodule

//--- src/aluControl.sv
`timescale 1ns/1ps

module aluControl import exStagePkg::*; (
    input  aluOpCode    aluOp,
    input  logic [5:0]  funct,
    output aluOperation operation
);

    localparam logic [5:0] functSll  = 6'h00;
    localparam logic [5:0] functSrl  = 6'h02;
    localparam logic [5:0] functSra  = 6'h03;
    localparam logic [5:0] functAdd  = 6'h20;
    localparam logic [5:0] functAddu = 6'h21;
    localparam logic [5:0] functSub  = 6'h22;
    localparam logic [5:0] functSubu = 6'h23;
    localparam logic [5:0] functAnd  = 6'h24;
    localparam logic [5:0] functOr   = 6'h25;
    localparam logic [5:0] functXor  = 6'h26;
    localparam logic [5:0] functNor  = 6'h27;
    localparam logic [5:0] functSlt  = 6'h2a;
    localparam logic [5:0] functSltu = 6'h2b;

    always_comb begin
        operation = aluAdd;
        case (aluOp)
            rType: begin
                // Unlisted funct codes fall back to add
                case (funct)
                    functAdd, functAddu: operation = aluAdd;
                    functSub, functSubu: operation = aluSub;
                    functAnd:            operation = aluAnd;
                    functOr:             operation = aluOr;
                    functXor:            operation = aluXor;
                    functNor:            operation = aluNor;
                    functSlt:            operation = aluSlt;
                    functSltu:           operation = aluSltu;
                    functSll:            operation = aluSll;
                    functSrl:            operation = aluSrl;
                    functSra:            operation = aluSra;
                    default:             operation = aluAdd;
                endcase
            end
            addOp:   operation = aluAdd;
            subOp:   operation = aluSub;
            andOp:   operation = aluAnd;
            orOp:    operation = aluOr;
            sltOp:   operation = aluSlt;
            luiOp:   operation = aluLui;
            default: operation = aluAdd;
        endcase
    end

endmodule

//--- src/exStagePkg.sv
`include "exStage_config.svh"

package exStagePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [4:0]                 shamt;
        logic [5:0]                 funct;
    } rFormat;

    // The low 26 bits of this view also carry the jump index
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [15:0]                immediate;
    } iFormat;

    typedef union packed {
        rFormat rFmt;
        iFormat iFmt;
    } instrWord;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operation codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Coarse operation class from the main controller
    typedef enum logic [2:0] {
        rType, addOp, subOp, andOp, orOp, sltOp, luiOp
    } aluOpCode;

    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOperation;

    typedef enum logic [1:0] {
        fromRegister, fromMem, fromWb
    } fwdSelect;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        instrWord               instr;
        logic [`DATA_WIDTH-1:0] pc4;
        logic [`DATA_WIDTH-1:0] readData1;
        logic [`DATA_WIDTH-1:0] readData2;
        aluOpCode               aluOp;
        logic                   aluSrc;
        logic                   zeroExtend;
        logic                   shamtSel;
        logic                   regDst;
    } exRequest;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0]     aluResult;
        logic                       zero;
        logic [`DATA_WIDTH-1:0]     branchAddress;
        logic [`DATA_WIDTH-1:0]     jumpAddress;
        logic [`DATA_WIDTH-1:0]     pc4;
        logic [`REG_ADDR_WIDTH-1:0] destReg;
    } exResult;

    // Write port of a later stage, seen as a bypass source
    typedef struct packed {
        logic                       regWrite;
        logic [`REG_ADDR_WIDTH-1:0] destReg;
        logic [`DATA_WIDTH-1:0]     value;
    } fwdSource;

endpackage

//--- src/exStage_config.svh
`ifndef EXSTAGE_CONFIG_SVH
`define EXSTAGE_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage dimensions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Integer datapath width as fixed by the instruction set
`define DATA_WIDTH 32

// Register file index width for 32 architectural registers
`define REG_ADDR_WIDTH 5

// Width of the internal ALU operation code
`define ALU_OP_WIDTH 4

`endif

//--- src/executeStage.sv
`timescale 1ns/1ps

`include "exStage_config.svh"

module executeStage import exStagePkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  logic     inValid,
    output logic     inReady,
    input  exRequest inReq,

    input  fwdSource memFwd,
    input  fwdSource wbFwd,

    output logic     outValid,
    input  logic     outReady,
    output exResult  outRes
);

    aluOperation            operation;
    fwdSelect               forwardA;
    fwdSelect               forwardB;
    logic [`DATA_WIDTH-1:0] rsValue;
    logic [`DATA_WIDTH-1:0] rtValue;
    logic [`DATA_WIDTH-1:0] immExtended;
    logic [`DATA_WIDTH-1:0] operandA;
    logic [`DATA_WIDTH-1:0] operandB;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic                   aluZero;
    logic [`DATA_WIDTH-1:0] branchAddress;
    logic [`DATA_WIDTH-1:0] jumpAddress;
    logic                   inFire;
    exResult                nextRes;

    // Bypass selection shared by both operands
    function automatic logic [`DATA_WIDTH-1:0] fwdMux(
        input fwdSelect               sel,
        input logic [`DATA_WIDTH-1:0] regValue,
        input logic [`DATA_WIDTH-1:0] memValue,
        input logic [`DATA_WIDTH-1:0] wbValue
    );
        logic [`DATA_WIDTH-1:0] value;
        case (sel)
            fromMem: value = memValue;
            fromWb:  value = wbValue;
            default: value = regValue;
        endcase
        return value;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control decode and hazards
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    aluControl aluCtrl0 (
        .aluOp     (inReq.aluOp),
        .funct     (inReq.instr.rFmt.funct),
        .operation (operation)
    );

    forwardUnit fwd0 (
        .rs       (inReq.instr.iFmt.rs),
        .rt       (inReq.instr.iFmt.rt),
        .memFwd   (memFwd),
        .wbFwd    (wbFwd),
        .forwardA (forwardA),
        .forwardB (forwardB)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rsValue = fwdMux(forwardA, inReq.readData1, memFwd.value, wbFwd.value);
    assign rtValue = fwdMux(forwardB, inReq.readData2, memFwd.value, wbFwd.value);

    // Logic immediates are zero extended, arithmetic ones sign extended
    assign immExtended = inReq.zeroExtend
        ? {{(`DATA_WIDTH-16){1'b0}}, inReq.instr.iFmt.immediate}
        : {{(`DATA_WIDTH-16){inReq.instr.iFmt.immediate[15]}}, inReq.instr.iFmt.immediate};

    assign operandA = inReq.shamtSel
        ? {{(`DATA_WIDTH-5){1'b0}}, inReq.instr.rFmt.shamt}
        : rsValue;

    assign operandB = inReq.aluSrc ? immExtended : rtValue;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    alu alu0 (
        .operation (operation),
        .a         (operandA),
        .b         (operandB),
        .result    (aluResult),
        .zero      (aluZero)
    );

    targetCalc targets0 (
        .instr         (inReq.instr),
        .pc4           (inReq.pc4),
        .branchAddress (branchAddress),
        .jumpAddress   (jumpAddress)
    );

    always_comb begin
        nextRes.aluResult     = aluResult;
        nextRes.zero          = aluZero;
        nextRes.branchAddress = branchAddress;
        nextRes.jumpAddress   = jumpAddress;
        nextRes.pc4           = inReq.pc4;
        nextRes.destReg       = inReq.regDst ? inReq.instr.rFmt.rd : inReq.instr.rFmt.rt;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The slot accepts when empty or when it is drained in the same cycle
    assign inReady = !outValid || outReady;
    assign inFire  = inValid && inReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inFire) begin
            outRes <= nextRes;
        end
    end

endmodule

//--- src/forwardUnit.sv
`timescale 1ns/1ps

`include "exStage_config.svh"

module forwardUnit import exStagePkg::*; (
    input  logic [`REG_ADDR_WIDTH-1:0] rs,
    input  logic [`REG_ADDR_WIDTH-1:0] rt,
    input  fwdSource                   memFwd,
    input  fwdSource                   wbFwd,
    output fwdSelect                   forwardA,
    output fwdSelect                   forwardB
);

    // True when a later stage will write the register being read
    function automatic logic hits(
        input fwdSource                   source,
        input logic [`REG_ADDR_WIDTH-1:0] srcReg
    );
        return source.regWrite && (source.destReg != '0) && (source.destReg == srcReg);
    endfunction

    // The MEM stage holds the younger value, so it is checked first
    function automatic fwdSelect pick(
        input logic [`REG_ADDR_WIDTH-1:0] srcReg,
        input fwdSource                   mem,
        input fwdSource                   wb
    );
        fwdSelect sel;
        if (hits(mem, srcReg)) begin
            sel = fromMem;
        end else if (hits(wb, srcReg)) begin
            sel = fromWb;
        end else begin
            sel = fromRegister;
        end
        return sel;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand selects
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        forwardA = pick(rs, memFwd, wbFwd);
    end

    always_comb begin
        forwardB = pick(rt, memFwd, wbFwd);
    end

endmodule

//--- src/targetCalc.sv
`timescale 1ns/1ps

`include "exStage_config.svh"

module targetCalc import exStagePkg::*; (
    input  instrWord               instr,
    input  logic [`DATA_WIDTH-1:0] pc4,
    output logic [`DATA_WIDTH-1:0] branchAddress,
    output logic [`DATA_WIDTH-1:0] jumpAddress
);

    logic [`DATA_WIDTH-1:0] immSigned;
    logic [25:0]            jumpIndex;

    assign immSigned = {{(`DATA_WIDTH-16){instr.iFmt.immediate[15]}}, instr.iFmt.immediate};

    // Everything below the opcode forms the jump index
    assign jumpIndex = {instr.iFmt.rs, instr.iFmt.rt, instr.iFmt.immediate};

    // Word offset relative to the following instruction
    assign branchAddress = pc4 + {immSigned[`DATA_WIDTH-3:0], 2'b00};

    // Jumps stay inside the current 256 MB region
    assign jumpAddress = {pc4[`DATA_WIDTH-1:`DATA_WIDTH-4], jumpIndex, 2'b00};

endmodule

//--- testbench/executeStage_asserts.sv
`timescale 1ns/1ps

module executeStageAsserts import exStagePkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    inReady,
    input logic    outValid,
    input logic    outReady,
    input exResult outRes
);

    int failCount = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output slot handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    resetClearsValid: assert property (
        @(posedge clk) reset |=> !outValid
    ) else begin
        failCount++;
        $error("outValid is still high one cycle after reset");
    end

    // A stalled consumer must see the same result until it takes it
    stallHoldsOutput: assert property (
        @(posedge clk) disable iff (reset)
        (outValid && !outReady) |=> (outValid && $stable(outRes))
    ) else begin
        failCount++;
        $error("The output changed while the consumer was stalling");
    end

    readyFollowsSlot: assert property (
        @(posedge clk) disable iff (reset)
        inReady == (!outValid || outReady)
    ) else begin
        failCount++;
        $error("inReady does not follow the state of the output slot");
    end

endmodule

bind executeStage executeStageAsserts asserts0 (
    .clk      (clk),
    .reset    (reset),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .outRes   (outRes)
);

//--- testbench/executeStage_tb.sv
`timescale 1ns/1ps

`include "exStage_config.svh"

module executeStage_tb import exStagePkg::*; ();

    localparam int waitLimit = 1000;

    // Supported R-type funct codes with the three shifts at indices 10 to 12
    localparam logic [12:0][5:0] rFuncts = {6'h03, 6'h02, 6'h00, 6'h2b, 6'h2a, 6'h27,
                                            6'h26, 6'h25, 6'h24, 6'h23, 6'h22, 6'h21, 6'h20};

    logic     clk;
    logic     reset;
    logic     inValid;
    logic     inReady;
    exRequest inReq;
    fwdSource memFwd;
    fwdSource wbFwd;
    logic     outValid;
    logic     outReady;
    exResult  outRes;

    integer   seed;
    logic     stallMode;
    int       acceptCount;
    exResult  expectedQ[$];

    executeStage dut0 (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .inReady  (inReady),
        .inReq    (inReq),
        .memFwd   (memFwd),
        .wbFwd    (wbFwd),
        .outValid (outValid),
        .outReady (outReady),
        .outRes   (outRes)
    );

    always #2 clk = ~clk;

    task automatic abortRun();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // WB is applied first so that a matching MEM source overrides it
    function automatic logic [`DATA_WIDTH-1:0] bypass(input logic [4:0] src,
            input logic [`DATA_WIDTH-1:0] regValue, input fwdSource mem, input fwdSource wb);
        logic [`DATA_WIDTH-1:0] value;
        value = regValue;
        if (wb.regWrite && wb.destReg == src && src != 5'd0) value = wb.value;
        if (mem.regWrite && mem.destReg == src && src != 5'd0) value = mem.value;
        return value;
    endfunction

    function automatic exResult modelResult(input exRequest req, input fwdSource mem,
                                            input fwdSource wb);
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] imm;
        logic [`DATA_WIDTH-1:0] res;
        exResult                r;
        a   = bypass(req.instr[25:21], req.readData1, mem, wb);
        b   = bypass(req.instr[20:16], req.readData2, mem, wb);
        imm = {{16{req.instr[15]}}, req.instr[15:0]};
        if (req.shamtSel) a = {27'd0, req.instr[10:6]};
        if (req.aluSrc) b = req.zeroExtend ? {16'd0, req.instr[15:0]} : imm;
        case (req.aluOp)
            rType: begin
                case (req.instr[5:0])
                    6'h22, 6'h23: res = a - b;
                    6'h24:        res = a & b;
                    6'h25:        res = a | b;
                    6'h26:        res = a ^ b;
                    6'h27:        res = ~(a | b);
                    6'h2a:        res = {31'd0, $signed(a) < $signed(b)};
                    6'h2b:        res = {31'd0, a < b};
                    6'h00:        res = b << a[4:0];
                    6'h02:        res = b >> a[4:0];
                    6'h03:        res = $signed(b) >>> a[4:0];
                    default:      res = a + b;
                endcase
            end
            subOp:   res = a - b;
            andOp:   res = a & b;
            orOp:    res = a | b;
            sltOp:   res = {31'd0, $signed(a) < $signed(b)};
            luiOp:   res = {b[15:0], 16'd0};
            default: res = a + b;
        endcase
        r.aluResult     = res;
        r.zero          = (res == 32'd0);
        r.branchAddress = req.pc4 + (imm << 2);
        r.jumpAddress   = {req.pc4[31:28], req.instr[25:0], 2'b00};
        r.pc4           = req.pc4;
        r.destReg       = req.regDst ? req.instr[15:11] : req.instr[20:16];
        return r;
    endfunction

    // The scoreboard samples on the rising edge while inputs change on the falling edge
    always @(posedge clk) begin
        exResult expected;
        if (!reset) begin
            if (dut0.asserts0.failCount != 0) begin
                $display("A handshake assertion on the execute stage failed");
                abortRun();
            end
            // The one-deep output slot holds exactly the items still owed
            checkValue("outValid", expectedQ.size() != 0, outValid);
            if (outValid && outReady) begin
                expected = expectedQ.pop_front();
                checkValue("aluResult", expected.aluResult, outRes.aluResult);
                checkValue("zero", expected.zero, outRes.zero);
                checkValue("branchAddress", expected.branchAddress, outRes.branchAddress);
                checkValue("jumpAddress", expected.jumpAddress, outRes.jumpAddress);
                checkValue("pc4", expected.pc4, outRes.pc4);
                checkValue("destReg", expected.destReg, outRes.destReg);
            end
            if (inValid && inReady) begin
                expectedQ.push_back(modelResult(inReq, memFwd, wbFwd));
                acceptCount++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stepCycle();
        @(negedge clk);
        outReady = stallMode ? (($random(seed) % 2) != 0) : 1'b1;
    endtask

    // Destinations are biased toward rs, rt and register 0
    task automatic makeSource(input logic [4:0] rs, input logic [4:0] rt,
                              output fwdSource src);
        int pick;
        src.regWrite = ($random(seed) % 2) != 0;
        src.value    = $random(seed);
        pick         = $unsigned($random(seed)) % 4;
        case (pick)
            0:       src.destReg = rs;
            1:       src.destReg = rt;
            2:       src.destReg = 5'd0;
            default: src.destReg = 5'($random(seed));
        endcase
    endtask

    task automatic sendItem(input exRequest req, input fwdSource mem, input fwdSource wb);
        int startCount;
        int waited;
        if (stallMode && ($random(seed) % 2 != 0)) begin
            inValid = 1'b0;
            stepCycle();
        end
        inValid    = 1'b1;
        inReq      = req;
        memFwd     = mem;
        wbFwd      = wb;
        startCount = acceptCount;
        waited     = 0;
        stepCycle();
        while (acceptCount == startCount) begin
            if (waited == waitLimit) begin
                $display("Timed out waiting for the stage to accept an input");
                abortRun();
            end
            waited++;
            stepCycle();
        end
    endtask

    // Kind 0 is R-type, 1 is I-type, anything else a shift by shamt
    task automatic runItem(input int kind);
        exRequest req;
        fwdSource mem;
        fwdSource wb;
        int       pick;
        req           = '0;
        req.instr     = $random(seed);
        req.pc4       = $random(seed);
        req.readData1 = $random(seed);
        req.readData2 = ($random(seed) % 4 == 0) ? req.readData1 : $random(seed);
        if ($random(seed) % 8 == 0) req.instr[25:21] = 5'd0;
        case (kind)
            0: begin
                pick           = $unsigned($random(seed)) % 13;
                req.instr[5:0] = rFuncts[pick];
                req.aluOp      = rType;
                req.regDst     = 1'b1;
            end
            1: begin
                // addi, subtract for beq, andi, ori, slti, lui
                pick           = $unsigned($random(seed)) % 6;
                req.aluOp      = aluOpCode'(pick + 1);
                req.aluSrc     = (req.aluOp != subOp);
                req.zeroExtend = (req.aluOp == andOp) || (req.aluOp == orOp);
            end
            default: begin
                pick           = 10 + $unsigned($random(seed)) % 3;
                req.instr[5:0] = rFuncts[pick];
                req.aluOp      = rType;
                req.shamtSel   = 1'b1;
                req.regDst     = 1'b1;
            end
        endcase
        makeSource(req.instr[25:21], req.instr[20:16], mem);
        makeSource(req.instr[25:21], req.instr[20:16], wb);
        sendItem(req, mem, wb);
    endtask

    initial begin
        int waited;
        seed        = 32'h678f_e779;
        clk         = 1'b0;
        reset       = 1'b1;
        inValid     = 1'b0;
        inReq       = '0;
        memFwd      = '0;
        wbFwd       = '0;
        outReady    = 1'b0;
        stallMode   = 1'b0;
        acceptCount = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        outReady = 1'b1;

        repeat (200) runItem(0);
        repeat (200) runItem(1);
        repeat (150) runItem(2);
        repeat (300) runItem($unsigned($random(seed)) % 3);
        stallMode = 1'b1;
        repeat (400) runItem($unsigned($random(seed)) % 3);

        stallMode = 1'b0;
        inValid   = 1'b0;
        waited    = 0;
        while (expectedQ.size() != 0) begin
            if (waited == waitLimit) begin
                $display("Timed out waiting for the remaining results to drain");
                abortRun();
            end
            waited++;
            stepCycle();
        end
        stepCycle();
        if (!outValid && dut0.asserts0.failCount == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("The stage still held a result or an assertion failed at the end");
            abortRun();
        end
    end

endmodule
